//--- rtl/cpu_pkg.sv
package cpu_pkg;

    // Core data and address width.
    localparam int xlen = 32;

    // First fetch address out of reset.
    localparam logic [xlen-1:0] reset_pc = '0;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h00000013;

    // Request unit sequencing.
    // s_ready is the single cycle in which the core may step.
    typedef enum logic [1:0] {
        s_fetch_wait,
        s_data_wait,
        s_ready,
        s_mul_wait
    } req_state_e;

endpackage

//--- rtl/bus_pkg.sv
package bus_pkg;

    // Memory depth in 32-bit words.
    localparam int mem_words = 32;

    // Word index width inside the byte address.
    localparam int mem_idx_w = $clog2(mem_words);

    // Cycles from request acceptance to response.
    localparam int mem_latency = 2;

    // Credits granted by the memory after reset.
    localparam int mem_credits = 1;

    // Credit counter width.
    localparam int credit_w = $clog2(mem_credits + 1);

    typedef enum logic {
        op_read,
        op_write
    } bus_op_e;

endpackage

//--- rtl/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pc_advance,
    input  logic                     pc_load,
    input  logic [cpu_pkg::xlen-1:0] pc_target,
    output logic [cpu_pkg::xlen-1:0] pc
);

    // Redirect wins over sequential advance.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= cpu_pkg::reset_pc;
        end else if (pc_load) begin
            pc <= pc_target;
        end else if (pc_advance) begin
            pc <= pc + 32'd4;
        end
    end

endmodule

//--- rtl/request_unit.sv
`timescale 1ns/1ps

module request_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [cpu_pkg::xlen-1:0] imm,
    input  logic                     branch_cond,
    input  logic                     jal,
    input  logic                     jalr,
    input  logic [cpu_pkg::xlen-1:0] jalr_target,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  logic [cpu_pkg::xlen-1:0] mem_addr,
    input  logic [cpu_pkg::xlen-1:0] store_data,
    input  logic                     mul_en,
    input  logic                     mul_done,
    input  logic [cpu_pkg::xlen-1:0] pc,
    input  logic                     resp_valid,
    input  logic [cpu_pkg::xlen-1:0] resp_rdata,
    input  logic                     credit_return,
    output logic                     pc_advance,
    output logic                     pc_load,
    output logic [cpu_pkg::xlen-1:0] pc_target,
    output logic                     req_valid,
    output bus_pkg::bus_op_e         req_op,
    output logic [cpu_pkg::xlen-1:0] req_addr,
    output logic [cpu_pkg::xlen-1:0] req_wdata,
    output logic [cpu_pkg::xlen-1:0] instruction,
    output logic                     instr_valid,
    output logic [cpu_pkg::xlen-1:0] load_data,
    output logic                     load_valid,
    output logic                     freeze
);

    cpu_pkg::req_state_e             state;
    logic [bus_pkg::credit_w-1:0]    credits;
    logic                            boot;
    logic                            fetch_pend;
    logic                            data_read;
    logic [cpu_pkg::xlen-1:0]        instr_q;
    logic                            step;
    logic                            data_step;
    logic                            pend_issue;
    logic                            redirect;
    logic [cpu_pkg::xlen-1:0]        next_pc;

    // The core steps only when an instruction is ready and a credit is free.
    assign step       = (state == cpu_pkg::s_ready) && (credits != '0);
    assign data_step  = step && !mul_en && (mem_read || mem_write);
    assign pend_issue = (state == cpu_pkg::s_fetch_wait) && fetch_pend && (credits != '0);
    assign redirect   = branch_cond || jal || jalr;

    always_comb begin
        if (branch_cond || jal) begin
            next_pc = pc + imm;
        end else if (jalr) begin
            next_pc = jalr_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    assign pc_load    = step && redirect;
    assign pc_advance = step && !redirect;
    assign pc_target  = next_pc;

    // Fetch goes out on the step edge itself unless a data access or a multiply comes first.
    assign req_valid = (step && !mul_en) || pend_issue;
    assign req_wdata = store_data;

    always_comb begin
        req_op   = bus_pkg::op_read;
        req_addr = pc;
        if (data_step) begin
            req_op   = mem_write ? bus_pkg::op_write : bus_pkg::op_read;
            req_addr = mem_addr;
        end else if (step) begin
            req_addr = next_pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= cpu_pkg::s_fetch_wait;
            boot       <= 1'b1;
            fetch_pend <= 1'b0;
            data_read  <= 1'b0;
        end else begin
            boot <= 1'b0;
            case (state)
                cpu_pkg::s_fetch_wait: begin
                    if (boot) begin
                        fetch_pend <= 1'b1;
                    end else if (pend_issue) begin
                        fetch_pend <= 1'b0;
                    end
                    if (resp_valid) begin
                        state <= cpu_pkg::s_ready;
                    end
                end
                cpu_pkg::s_data_wait: begin
                    if (resp_valid) begin
                        state      <= cpu_pkg::s_fetch_wait;
                        fetch_pend <= 1'b1;
                    end
                end
                cpu_pkg::s_mul_wait: begin
                    if (mul_done) begin
                        state      <= cpu_pkg::s_fetch_wait;
                        fetch_pend <= 1'b1;
                    end
                end
                default: begin
                    if (step) begin
                        data_read <= mem_read;
                        if (mul_en) begin
                            state <= cpu_pkg::s_mul_wait;
                        end else if (mem_read || mem_write) begin
                            state <= cpu_pkg::s_data_wait;
                        end else begin
                            state <= cpu_pkg::s_fetch_wait;
                        end
                    end
                end
            endcase
        end
    end

    // One credit per request, returned with its response.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= bus_pkg::credit_w'(bus_pkg::mem_credits);
        end else begin
            case ({req_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::s_fetch_wait && resp_valid) begin
            instr_q <= resp_rdata;
        end
    end

    // Held word is shown once, so a stall never replays it.
    assign instr_valid = step;
    assign freeze      = !step;
    assign instruction = step ? instr_q : cpu_pkg::nop_instr;

    assign load_valid = (state == cpu_pkg::s_data_wait) && resp_valid && data_read;
    assign load_data  = resp_rdata;

endmodule

//--- rtl/mem_port.sv
`timescale 1ns/1ps

module mem_port (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  bus_pkg::bus_op_e         req_op,
    input  logic [cpu_pkg::xlen-1:0] req_addr,
    input  logic [cpu_pkg::xlen-1:0] req_wdata,
    output logic                     resp_valid,
    output logic [cpu_pkg::xlen-1:0] resp_rdata,
    output logic                     credit_return
);

    logic [cpu_pkg::xlen-1:0]       mem [bus_pkg::mem_words];
    logic [bus_pkg::mem_idx_w-1:0]  idx;

    // Stage 0 captures the access, the remaining stages model the latency.
    logic [bus_pkg::mem_latency:0]  pipe_v;
    logic [cpu_pkg::xlen-1:0]       pipe_d [bus_pkg::mem_latency+1];

    initial begin
        $readmemh("program.hex", mem);
    end

    // Byte address to word index.
    assign idx = req_addr[bus_pkg::mem_idx_w+1:2];

    always_ff @(posedge clk) begin
        if (req_valid && req_op == bus_pkg::op_write) begin
            mem[idx] <= req_wdata;
        end
        pipe_d[0] <= mem[idx];
        for (int i = 1; i <= bus_pkg::mem_latency; i++) begin
            pipe_d[i] <= pipe_d[i-1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pipe_v <= '0;
        end else begin
            pipe_v <= {pipe_v[bus_pkg::mem_latency-1:0], req_valid};
        end
    end

    assign resp_valid    = pipe_v[bus_pkg::mem_latency];
    assign resp_rdata    = pipe_d[bus_pkg::mem_latency];
    // Credit comes back with every response.
    assign credit_return = resp_valid;

endmodule

//--- rtl/fetch_mem_top.sv
`timescale 1ns/1ps

module fetch_mem_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [cpu_pkg::xlen-1:0] imm,
    input  logic                     branch_cond,
    input  logic                     jal,
    input  logic                     jalr,
    input  logic [cpu_pkg::xlen-1:0] jalr_target,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  logic [cpu_pkg::xlen-1:0] mem_addr,
    input  logic [cpu_pkg::xlen-1:0] store_data,
    input  logic                     mul_en,
    input  logic                     mul_done,
    output logic [cpu_pkg::xlen-1:0] instruction,
    output logic                     instr_valid,
    output logic [cpu_pkg::xlen-1:0] load_data,
    output logic                     load_valid,
    output logic                     freeze,
    output logic [cpu_pkg::xlen-1:0] pc
);

    logic                     pc_advance;
    logic                     pc_load;
    logic [cpu_pkg::xlen-1:0] pc_target;
    logic                     req_valid;
    bus_pkg::bus_op_e         req_op;
    logic [cpu_pkg::xlen-1:0] req_addr;
    logic [cpu_pkg::xlen-1:0] req_wdata;
    logic                     resp_valid;
    logic [cpu_pkg::xlen-1:0] resp_rdata;
    logic                     credit_return;

    pc_unit pc_unit0 (
        .clk        (clk),
        .rst        (rst),
        .pc_advance (pc_advance),
        .pc_load    (pc_load),
        .pc_target  (pc_target),
        .pc         (pc)
    );

    request_unit request_unit0 (
        .clk           (clk),
        .rst           (rst),
        .imm           (imm),
        .branch_cond   (branch_cond),
        .jal           (jal),
        .jalr          (jalr),
        .jalr_target   (jalr_target),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .store_data    (store_data),
        .mul_en        (mul_en),
        .mul_done      (mul_done),
        .pc            (pc),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .credit_return (credit_return),
        .pc_advance    (pc_advance),
        .pc_load       (pc_load),
        .pc_target     (pc_target),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .instruction   (instruction),
        .instr_valid   (instr_valid),
        .load_data     (load_data),
        .load_valid    (load_valid),
        .freeze        (freeze)
    );

    mem_port mem_port0 (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .credit_return (credit_return)
    );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset covers the first four rising edges.
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- bench/tb_fetch_mem.sv
`timescale 1ns/1ps

module tb_fetch_mem;

    localparam int wait_limit = 40;

    typedef enum {k_plain, k_branch, k_jal, k_jalr, k_store, k_load, k_mul} step_kind_e;

    logic        clk;
    logic        rst;
    logic [31:0] imm;
    logic        branch_cond;
    logic        jal;
    logic        jalr;
    logic [31:0] jalr_target;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] store_data;
    logic        mul_en;
    logic        mul_done;
    logic [31:0] instruction;
    logic        instr_valid;
    logic [31:0] load_data;
    logic        load_valid;
    logic        freeze;
    logic [31:0] pc;

    logic [31:0] ref_mem [bus_pkg::mem_words];
    logic [31:0] exp_pc = cpu_pkg::reset_pc;
    logic [31:0] exp_load = '0;
    logic        load_pend = 1'b0;
    logic        mul_pend = 1'b0;
    logic        timed_step = 1'b0;
    logic        timed_out = 1'b0;
    int          mul_delay = 2;
    int          check_count = 0;
    int          error_count = 0;
    int          timeout_count = 0;
    int          valid_errors = 0;
    int          nop_errors = 0;

    // Mix of fetch-only, redirect, memory and multiply steps.
    step_kind_e schedule [23] = '{
        k_plain, k_plain, k_plain, k_plain, k_plain, k_plain,
        k_branch, k_jal, k_branch, k_jal, k_plain, k_jalr, k_plain, k_jalr,
        k_store, k_load, k_plain, k_load, k_mul, k_plain, k_mul, k_plain, k_plain
    };

    clock_gen clock_gen0 (
        .clk (clk),
        .rst (rst)
    );

    fetch_mem_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .imm         (imm),
        .branch_cond (branch_cond),
        .jal         (jal),
        .jalr        (jalr),
        .jalr_target (jalr_target),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .store_data  (store_data),
        .mul_en      (mul_en),
        .mul_done    (mul_done),
        .instruction (instruction),
        .instr_valid (instr_valid),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .freeze      (freeze),
        .pc          (pc)
    );

    // An instruction is valid exactly in the cycle the core may step.
    valid_is_step: assert property (@(negedge clk) disable iff (rst) instr_valid == !freeze)
        else begin
            valid_errors++;
            $display("** Error: instr_valid = %h, freeze = %h", instr_valid, freeze);
        end

    nop_when_idle: assert property (@(negedge clk) disable iff (rst)
        !instr_valid |-> instruction == cpu_pkg::nop_instr)
        else begin
            nop_errors++;
            $display("** Error: instruction = %h, expected %h", instruction, cpu_pkg::nop_instr);
        end

    function automatic logic [bus_pkg::mem_idx_w-1:0] word_index(input logic [31:0] addr);
        logic [31:0] word;
        word = addr >> 2;
        return word[bus_pkg::mem_idx_w-1:0];
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // Waits for the next ready cycle and checks what the last step produced.
    task automatic await_step();
        int   frozen;
        int   loads;
        logic mul_given;
        frozen = 0;
        loads = 0;
        mul_given = 1'b0;
        @(negedge clk);
        while (freeze) begin
            check_word("instr_valid", {31'd0, instr_valid}, 32'd0);
            if (load_valid) begin
                loads++;
                assert (load_pend) else begin
                    error_count++;
                    $display("load_valid pulsed although no load was issued");
                end
                if (load_pend) begin
                    check_word("load_data", load_data, exp_load);
                end
            end
            frozen++;
            if (frozen > wait_limit) begin
                timeout_count++;
                timed_out = 1'b1;
                $display("timeout after %0d cycles waiting for freeze to fall", frozen);
                return;
            end
            @(posedge clk);
            // Multiplier finishes after a random number of cycles.
            if (mul_pend && !mul_given && frozen >= mul_delay) begin
                mul_done <= 1'b1;
                mul_given = 1'b1;
            end else begin
                mul_done <= 1'b0;
            end
            @(negedge clk);
        end
        check_word("pc", pc, exp_pc);
        check_word("instruction", instruction, ref_mem[word_index(exp_pc)]);
        if (timed_step) begin
            check_word("freeze cycles", 32'(frozen), 32'(bus_pkg::mem_latency + 1));
        end
        if (load_pend) begin
            check_word("load_valid pulses", 32'(loads), 32'd1);
        end
        assert (!mul_pend || mul_given) else begin
            error_count++;
            $display("freeze fell before mul_done was given");
        end
        // Controls now on the inputs are taken at the coming edge.
        timed_step = !(mem_read || mem_write || mul_en);
        load_pend = mem_read && !mul_en;
        mul_pend = mul_en;
        if (mem_write) begin
            ref_mem[word_index(mem_addr)] = store_data;
        end
        if (mem_read) begin
            exp_load = ref_mem[word_index(mem_addr)];
        end
        if (branch_cond || jal) begin
            exp_pc = exp_pc + imm;
        end else if (jalr) begin
            exp_pc = jalr_target;
        end else begin
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic issue_step(input logic br, input logic jl, input logic jr,
                              input logic [31:0] offset, input logic [31:0] target,
                              input logic rd, input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic mul);
        @(posedge clk);
        branch_cond <= br;
        jal         <= jl;
        jalr        <= jr;
        imm         <= offset;
        jalr_target <= target;
        mem_read    <= rd;
        mem_write   <= wr;
        mem_addr    <= addr;
        store_data  <= wdata;
        mul_en      <= mul;
        mul_done    <= 1'b0;
        await_step();
    endtask

    task automatic run_program();
        logic [31:0] target;
        logic [31:0] addr;
        logic [31:0] data;
        addr = '0;
        foreach (schedule[i]) begin
            // Jump targets stay in the lower half, data lives in the top eight words.
            target = ($urandom % (bus_pkg::mem_words / 2)) << 2;
            data = $urandom;
            case (schedule[i])
                k_branch: issue_step(1'b1, 1'b0, 1'b0, target - exp_pc, '0,
                                     1'b0, 1'b0, '0, '0, 1'b0);
                k_jal:    issue_step(1'b0, 1'b1, 1'b0, target - exp_pc, '0,
                                     1'b0, 1'b0, '0, '0, 1'b0);
                k_jalr:   issue_step(1'b0, 1'b0, 1'b1, '0, target,
                                     1'b0, 1'b0, '0, '0, 1'b0);
                k_store: begin
                    addr = (32'(bus_pkg::mem_words - 8) + ($urandom % 8)) << 2;
                    issue_step(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, 1'b1, addr, data, 1'b0);
                end
                k_load:   issue_step(1'b0, 1'b0, 1'b0, '0, '0, 1'b1, 1'b0, addr, '0, 1'b0);
                k_mul: begin
                    mul_delay = 2 + int'($urandom % 5);
                    issue_step(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0, 1'b1);
                end
                default:  issue_step(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0, 1'b0);
            endcase
            if (timed_out) begin
                return;
            end
        end
    endtask

    initial begin
        int n;
        n = 0;
        void'($urandom(66));
        $readmemh("program.hex", ref_mem);
        imm         <= '0;
        branch_cond <= 1'b0;
        jal         <= 1'b0;
        jalr        <= 1'b0;
        jalr_target <= '0;
        mem_read    <= 1'b0;
        mem_write   <= 1'b0;
        mem_addr    <= '0;
        store_data  <= '0;
        mul_en      <= 1'b0;
        mul_done    <= 1'b0;
        do begin
            @(negedge clk);
            n++;
        end while (rst && n < wait_limit);
        if (rst) begin
            timeout_count++;
            $display("timeout waiting for reset to be released");
        end else begin
            // Core stays frozen until the first fetch returns.
            @(negedge clk);
            check_word("freeze", {31'd0, freeze}, 32'd1);
            run_program();
        end
        $display("checks %0d, errors %0d, valid errors %0d, nop errors %0d, timeouts %0d",
                 check_count, error_count, valid_errors, nop_errors, timeout_count);
        if (error_count + valid_errors + nop_errors + timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- program.hex
// One 32-bit word per line in hex, word address 0 upward; words 24 to 31 hold data.
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
01100893
01200913
01300993
01400a13
01500a93
01600b13
01700b93
01800c13
deadbeef
cafef00d
12345678
0badc0de
5a5a5a5a
a5a5a5a5
0f0f0f0f
f0f0f0f0

//--- all.f
rtl/cpu_pkg.sv
rtl/bus_pkg.sv
rtl/pc_unit.sv
rtl/request_unit.sv
rtl/mem_port.sv
rtl/fetch_mem_top.sv
bench/clock_gen.sv
bench/tb_fetch_mem.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_fetch_mem -f all.f -o tb_fetch_mem \
    && ./obj_dir/tb_fetch_mem > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
